/* amo_unit.f */
+incdir+.
amo_pkg.sv
amo_mem_if.sv
amo_wait_timer.sv
amo_alu.sv
amo_fsm.sv
amo_mem.sv
amo_unit_top.sv
amo_unit_asserts.sv
amo_unit_tb.sv

/* Bender.yml */
package:
  name: amo_unit

sources:
  # design
  - include_dirs:
      - .
    files:
      - amo_pkg.sv
      - amo_mem_if.sv
      - amo_wait_timer.sv
      - amo_alu.sv
      - amo_fsm.sv
      - amo_mem.sv
      - amo_unit_top.sv

  # testbench
  - target: test
    include_dirs:
      - .
    files:
      - amo_unit_asserts.sv
      - amo_unit_tb.sv

/* amo_unit_stim.txt */
# name       op     adr  wdata     expected rsp_rdt, all numbers hex
# idle_gap lines pause 0 to 3 random cycles, their other columns are unused
wr_a00       write  00   12345678  00000000
rd_a00       read   00   00000000  12345678
wr_a01       write  01   ffffffff  00000000
wr_a02       write  02   0f0f0f0f  00000000
wr_a03       write  03   80000000  00000000
wr_a3f       write  3f   a5a5a5a5  00000000
idle_gap     -      00   00000000  00000000
rd_a3f       read   3f   00000000  a5a5a5a5
swap_a00     swap   00   cafef00d  12345678
rd_swap      read   00   00000000  cafef00d
add_a01      add    01   00000002  ffffffff
rd_add       read   01   00000000  00000001
xor_a02      xor    02   ff00ff00  0f0f0f0f
rd_xor       read   02   00000000  f00ff00f
idle_gap     -      00   00000000  00000000
and_a02      and    02   ffff0000  f00ff00f
rd_and       read   02   00000000  f00f0000
or_a02       or     02   0000ffff  f00f0000
rd_or        read   02   00000000  f00fffff
min_a03      min    03   00000001  80000000
rd_min       read   03   00000000  80000000
minu_a03     minu   03   00000001  80000000
rd_minu      read   03   00000000  00000001
wr_a04       write  04   80000000  00000000
max_a04      max    04   00000001  80000000
rd_max       read   04   00000000  00000001
wr_a05       write  05   80000000  00000000
maxu_a05     maxu   05   00000001  80000000
rd_maxu      read   05   00000000  80000000
idle_gap     -      00   00000000  00000000
wr_a06       write  06   00000005  00000000
min_a06      min    06   fffffffe  00000005
rd_min_neg   read   06   00000000  fffffffe

/* amo_unit_tb.sv */
// amo unit testbench: replays the stimulus file, checks responses and latency
`timescale 1ns/1ps
`default_nettype none

`include "amo_settings.svh"

module amo_unit_tb;

    localparam int W         = `AMO_MEM_WAIT;
    localparam int RESET_CYC = 16;
    // watchdog budget per stimulus line
    localparam int LINE_CYC  = 2 * W + 8;

    logic                  clk;
    logic                  arst_n;
    logic                  req_vld;
    logic                  req_rdy;
    amo_pkg::amo_op_e      req_op;
    logic [`AMO_ADR_W-1:0] req_adr;
    logic [`AMO_DAT_W-1:0] req_wdt;
    logic                  rsp_vld;
    logic [`AMO_DAT_W-1:0] rsp_rdt;

    // vectors, one entry per stimulus line
    string                 v_name[$];
    amo_pkg::amo_op_e      v_op[$];
    logic [`AMO_ADR_W-1:0] v_adr[$];
    logic [`AMO_DAT_W-1:0] v_wdt[$];
    logic [`AMO_DAT_W-1:0] v_exp[$];

    int     errors;
    int     tests;
    int     failed;
    integer seed;
    bit     loaded;

    initial clk = 1'b0;
    always #5 clk = ~clk;

    amo_unit_top dut_i (
        .clk     (clk),
        .arst_n  (arst_n),
        .req_vld (req_vld),
        .req_rdy (req_rdy),
        .req_op  (req_op),
        .req_adr (req_adr),
        .req_wdt (req_wdt),
        .rsp_vld (rsp_vld),
        .rsp_rdt (rsp_rdt)
    );

    bind amo_unit_top amo_unit_asserts asserts_i (
        .clk     (clk),
        .arst_n  (arst_n),
        .req_vld (req_vld),
        .req_rdy (req_rdy),
        .rsp_vld (rsp_vld),
        .mem_en  (mem_bus.en),
        .mem_adr (mem_bus.adr)
    );

    //////////////////////////////////////////////////
    // stimulus file
    //////////////////////////////////////////////////

    // opcode column to enum, 0 for an unknown word
    function automatic bit op_from_name(input string s, output amo_pkg::amo_op_e op);
        bit ok;
        ok = 1'b1;
        op = amo_pkg::OP_READ;
        case (s)
            "read":  op = amo_pkg::OP_READ;
            "write": op = amo_pkg::OP_WRITE;
            "swap":  op = amo_pkg::OP_SWAP;
            "add":   op = amo_pkg::OP_ADD;
            "xor":   op = amo_pkg::OP_XOR;
            "and":   op = amo_pkg::OP_AND;
            "or":    op = amo_pkg::OP_OR;
            "min":   op = amo_pkg::OP_MIN;
            "max":   op = amo_pkg::OP_MAX;
            "minu":  op = amo_pkg::OP_MINU;
            "maxu":  op = amo_pkg::OP_MAXU;
            default: ok = 1'b0;
        endcase
        return ok;
    endfunction

    task automatic load_vectors();
        int                    fd;
        int                    n;
        string                 line;
        string                 name;
        string                 opname;
        amo_pkg::amo_op_e      op;
        logic [`AMO_ADR_W-1:0] adr;
        logic [`AMO_DAT_W-1:0] wdt;
        logic [`AMO_DAT_W-1:0] exp_rdt;
        fd = $fopen("amo_unit_stim.txt", "r");
        if (fd == 0) begin
            $display("cannot open amo_unit_stim.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                n = $sscanf(line, "%s %s %h %h %h", name, opname, adr, wdt, exp_rdt);
                // comments and blank lines
                if (n < 5 || name.substr(0, 0) == "#") begin
                    continue;
                end
                op = amo_pkg::OP_READ;
                if (name != "idle_gap" && !op_from_name(opname, op)) begin
                    $display("unknown opcode %s in stimulus line %s", opname, name);
                    errors++;
                    continue;
                end
                v_name.push_back(name);
                v_op.push_back(op);
                v_adr.push_back(adr);
                v_wdt.push_back(wdt);
                v_exp.push_back(exp_rdt);
            end
            $fclose(fd);
        end
        loaded = (v_name.size() > 0);
    endtask

    //////////////////////////////////////////////////
    // test steps
    //////////////////////////////////////////////////

    // ready high and no response before any request
    task automatic reset_and_check();
        bit ok;
        ok = 1'b1;
        repeat (RESET_CYC) @(posedge clk);
        arst_n <= 1'b1;
        repeat (3) begin
            @(negedge clk);
            assert (req_rdy && !rsp_vld) else begin
                $display("Error: reset_state expected rdy 1 vld 0 actual rdy %b vld %b",
                         req_rdy, rsp_vld);
                errors++;
                ok = 1'b0;
            end
        end
        tests++;
        if (!ok) failed++;
        $display("%-12s %s", "reset_state", ok ? "ok" : "failed");
    endtask

    task automatic idle_gap();
        int gap;
        gap = $random(seed) & 3;
        repeat (gap) begin
            @(negedge clk);
            assert (req_rdy && !rsp_vld) else begin
                $display("DUT not idle during a gap between requests");
                errors++;
            end
        end
        $display("%-12s %0d cycles", "idle_gap", gap);
    endtask

    task automatic run_request(input int idx);
        int wait_cyc;
        int lat;
        int exp_lat;
        bit ok;
        ok = 1'b1;
        // read and write: W waits, strobe, response; atomic runs two phases
        if (v_op[idx] == amo_pkg::OP_READ || v_op[idx] == amo_pkg::OP_WRITE) begin
            exp_lat = W + 2;
        end else begin
            exp_lat = 2 * W + 4;
        end
        @(posedge clk);
        req_vld <= 1'b1;
        req_op  <= v_op[idx];
        req_adr <= v_adr[idx];
        req_wdt <= v_wdt[idx];
        // handshake, expected in the first cycle
        wait_cyc = 0;
        do begin
            @(negedge clk);
            wait_cyc++;
        end while (!req_rdy);
        assert (wait_cyc == 1) else begin
            $display("%s was not accepted in the cycle after the last response", v_name[idx]);
            errors++;
            ok = 1'b0;
        end
        @(posedge clk);
        req_vld <= 1'b0;
        // count to the response, ready stays low
        lat = 0;
        do begin
            @(negedge clk);
            lat++;
            assert (!req_rdy) else begin
                $display("req_rdy rose before the response of %s", v_name[idx]);
                errors++;
                ok = 1'b0;
            end
        end while (!rsp_vld);
        assert (rsp_rdt == v_exp[idx]) else begin
            $display("Error: %s expected %h actual %h", v_name[idx], v_exp[idx], rsp_rdt);
            errors++;
            ok = 1'b0;
        end
        assert (lat == exp_lat) else begin
            $display("Error: %s latency expected %0d actual %0d", v_name[idx], exp_lat, lat);
            errors++;
            ok = 1'b0;
        end
        tests++;
        if (!ok) failed++;
        $display("%-12s %s  rdt %h  latency %0d", v_name[idx], ok ? "ok" : "failed",
                 rsp_rdt, lat);
    endtask

    //////////////////////////////////////////////////
    // main sequence and watchdog
    //////////////////////////////////////////////////

    initial begin
        errors  = 0;
        tests   = 0;
        failed  = 0;
        seed    = 34196;
        loaded  = 1'b0;
        arst_n  = 1'b0;
        req_vld = 1'b0;
        req_op  = amo_pkg::OP_READ;
        req_adr = '0;
        req_wdt = '0;
        load_vectors();
        if (!loaded) begin
            $display("no stimulus could be read from amo_unit_stim.txt");
            errors++;
        end else begin
            reset_and_check();
            foreach (v_name[i]) begin
                if (v_name[i] == "idle_gap") begin
                    idle_gap();
                end else begin
                    run_request(i);
                end
            end
            repeat (2) @(posedge clk);
        end
        errors += dut_i.asserts_i.fail_cnt;
        $display("tests %0d, failed %0d, errors %0d, assertion failures %0d",
                 tests, failed, errors, dut_i.asserts_i.fail_cnt);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // reset, reset check, then the budget of every line
    initial begin : watchdog
        wait (loaded);
        repeat (RESET_CYC + 8 + v_name.size() * LINE_CYC) @(posedge clk);
        $display("timeout: the DUT did not finish the stimulus in time");
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* amo_unit_asserts.sv */
// amo unit assertions: response pulse, handshake and memory strobe rules
`timescale 1ns/1ps
`default_nettype none

`include "amo_settings.svh"

module amo_unit_asserts (
    input wire                  clk,
    input wire                  arst_n,
    input wire                  req_vld,
    input wire                  req_rdy,
    input wire                  rsp_vld,
    input wire                  mem_en,
    input wire [`AMO_ADR_W-1:0] mem_adr
);

    // failed assertion count, summed into the testbench result
    int   fail_cnt = 0;
    // one transaction between acceptance and response
    logic busy;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy <= 1'b0;
        end else if (req_vld && req_rdy) begin
            busy <= 1'b1;
        end else if (rsp_vld) begin
            busy <= 1'b0;
        end
    end

    //////////////////////////////////////////////////
    // rules
    //////////////////////////////////////////////////

    // response is a single-cycle pulse
    rsp_pulse_a: assert property (@(posedge clk) disable iff (!arst_n)
        rsp_vld |=> !rsp_vld)
        else begin
            $error("rsp_vld held high for more than one cycle");
            fail_cnt++;
        end

    // no new request while one is in flight
    rdy_low_a: assert property (@(posedge clk) disable iff (!arst_n)
        busy |-> !req_rdy)
        else begin
            $error("req_rdy high between acceptance and response");
            fail_cnt++;
        end

    // strobes only inside a transaction
    stb_busy_a: assert property (@(posedge clk) disable iff (!arst_n)
        mem_en |-> busy)
        else begin
            $error("memory strobe outside a transaction");
            fail_cnt++;
        end

    stb_adr_a: assert property (@(posedge clk) disable iff (!arst_n)
        mem_en |-> !$isunknown(mem_adr))
        else begin
            $error("memory address unknown during a strobe");
            fail_cnt++;
        end

endmodule

`default_nettype wire

/* amo_unit_top.sv */
// atomic memory operation unit: controller, timer, operand path and memory
`timescale 1ns/1ps
`default_nettype none

`include "amo_settings.svh"

module amo_unit_top (
    input  wire                      clk,
    input  wire                      arst_n,
    // request
    input  wire                      req_vld,
    output logic                     req_rdy,
    input  wire amo_pkg::amo_op_e    req_op,
    input  wire [`AMO_ADR_W-1:0]     req_adr,
    input  wire [`AMO_DAT_W-1:0]     req_wdt,
    // response
    output logic                     rsp_vld,
    output logic [`AMO_DAT_W-1:0]    rsp_rdt
);

    // controller to timer and operand path
    logic tmr_start;
    logic tmr_done;
    logic acc;
    logic cap;

    //////////////////////////////////////////////////
    // memory bus
    //////////////////////////////////////////////////

    amo_mem_if mem_bus ();

    //////////////////////////////////////////////////
    // blocks
    //////////////////////////////////////////////////

    amo_fsm fsm_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .req_vld   (req_vld),
        .req_rdy   (req_rdy),
        .req_op    (req_op),
        .req_adr   (req_adr),
        .rsp_vld   (rsp_vld),
        .tmr_start (tmr_start),
        .tmr_done  (tmr_done),
        .acc       (acc),
        .cap       (cap),
        .mem       (mem_bus.ctl)
    );

    amo_wait_timer tmr_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .tmr_start (tmr_start),
        .tmr_done  (tmr_done)
    );

    amo_alu alu_i (
        .clk     (clk),
        .arst_n  (arst_n),
        .acc     (acc),
        .cap     (cap),
        .req_op  (req_op),
        .req_wdt (req_wdt),
        .rsp_rdt (rsp_rdt),
        .mem     (mem_bus.opd)
    );

    amo_mem mem_i (
        .clk (clk),
        .mem (mem_bus.mem)
    );

endmodule

`default_nettype wire

/* amo_mem.sv */
// single-port word memory, synchronous write and registered read
`timescale 1ns/1ps
`default_nettype none

`include "amo_settings.svh"

module amo_mem (
    input  wire    clk,
    amo_mem_if.mem mem
);

    localparam int DEPTH = 2 ** `AMO_ADR_W;

    logic [`AMO_DAT_W-1:0] ram [DEPTH];

    //////////////////////////////////////////////////
    // access port
    //////////////////////////////////////////////////

    // one strobe, either write or read
    always_ff @(posedge clk) begin
        if (mem.en) begin
            if (mem.wen) begin
                ram[mem.adr] <= mem.wdt;
            end else begin
                // holds until the next read strobe
                mem.rdt <= ram[mem.adr];
            end
        end
    end

endmodule

`default_nettype wire

/* amo_fsm.sv */
// amo controller: sequences the read and write phases and the response
`timescale 1ns/1ps
`default_nettype none

`include "amo_settings.svh"

module amo_fsm (
    input  wire                      clk,
    input  wire                      arst_n,
    input  wire                      req_vld,
    output logic                     req_rdy,
    input  wire amo_pkg::amo_op_e    req_op,
    input  wire [`AMO_ADR_W-1:0]     req_adr,
    output logic                     rsp_vld,
    output logic                     tmr_start,
    input  wire                      tmr_done,
    output logic                     acc,
    output logic                     cap,
    amo_mem_if.ctl                   mem
);

    amo_pkg::amo_state_e   state_q;
    amo_pkg::amo_state_e   state_d;
    // opcode class, read vs write is carried by the phase itself
    logic                  amo_q;
    logic [`AMO_ADR_W-1:0] adr_q;

    //////////////////////////////////////////////////
    // handshake
    //////////////////////////////////////////////////

    assign req_rdy = (state_q == amo_pkg::ST_IDLE);
    assign acc     = req_vld & req_rdy;
    assign rsp_vld = (state_q == amo_pkg::ST_RESP);

    // timer runs from acceptance, and from the capture cycle of an atomic
    assign tmr_start = acc | (cap & amo_q);

    //////////////////////////////////////////////////
    // next state
    //////////////////////////////////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            amo_pkg::ST_IDLE: begin
                // zero wait states skip the wait state
                if (acc && req_op == amo_pkg::OP_WRITE) begin
                    state_d = tmr_done ? amo_pkg::ST_WR_STB : amo_pkg::ST_WR_WAIT;
                end else if (acc) begin
                    state_d = tmr_done ? amo_pkg::ST_RD_STB : amo_pkg::ST_RD_WAIT;
                end
            end
            amo_pkg::ST_RD_WAIT: begin
                if (tmr_done) begin
                    state_d = amo_pkg::ST_RD_STB;
                end
            end
            // atomic enters write wait, first cycle there is the capture
            amo_pkg::ST_RD_STB: begin
                state_d = amo_q ? amo_pkg::ST_WR_WAIT : amo_pkg::ST_RESP;
            end
            amo_pkg::ST_WR_WAIT: begin
                if (tmr_done) begin
                    state_d = amo_pkg::ST_WR_STB;
                end
            end
            amo_pkg::ST_WR_STB: state_d = amo_pkg::ST_RESP;
            default:            state_d = amo_pkg::ST_IDLE;
        endcase
    end

    //////////////////////////////////////////////////
    // registers
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= amo_pkg::ST_IDLE;
            amo_q   <= 1'b0;
            cap     <= 1'b0;
        end else begin
            state_q <= state_d;
            // capture pulse one cycle after the read strobe
            cap     <= (state_q == amo_pkg::ST_RD_STB);
            if (acc) begin
                amo_q <= (req_op != amo_pkg::OP_READ) && (req_op != amo_pkg::OP_WRITE);
            end
        end
    end

    // address held for both phases
    always_ff @(posedge clk) begin
        if (acc) begin
            adr_q <= req_adr;
        end
    end

    // memory strobes
    assign mem.en  = (state_q == amo_pkg::ST_RD_STB) || (state_q == amo_pkg::ST_WR_STB);
    assign mem.wen = (state_q == amo_pkg::ST_WR_STB);
    assign mem.adr = adr_q;

endmodule

`default_nettype wire

/* amo_alu.sv */
// amo operand path: operand and old-word registers, write-back combine logic
`timescale 1ns/1ps
`default_nettype none

`include "amo_settings.svh"

module amo_alu (
    input  wire                      clk,
    input  wire                      arst_n,
    input  wire                      acc,
    input  wire                      cap,
    input  wire amo_pkg::amo_op_e    req_op,
    input  wire [`AMO_DAT_W-1:0]     req_wdt,
    output logic [`AMO_DAT_W-1:0]    rsp_rdt,
    amo_mem_if.opd                   mem
);

    localparam int MSB = `AMO_DAT_W - 1;

    amo_pkg::amo_op_e      op_q;
    logic [`AMO_DAT_W-1:0] opd_q;   // requester operand
    logic [`AMO_DAT_W-1:0] old_q;   // old memory word
    logic                  sgn;
    logic [`AMO_DAT_W:0]   diff;
    logic                  lt;

    //////////////////////////////////////////////////
    // registers
    //////////////////////////////////////////////////

    // opcode selects the combine function
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            op_q <= amo_pkg::OP_READ;
        end else if (acc) begin
            op_q <= req_op;
        end
    end

    // operand at acceptance, old word at capture
    always_ff @(posedge clk) begin
        if (acc) begin
            opd_q <= req_wdt;
            // a plain write answers with zero
            old_q <= '0;
        end else if (cap) begin
            old_q <= mem.rdt;
        end
    end

    // plain read responds in its capture cycle, so bypass the register
    assign rsp_rdt = cap ? mem.rdt : old_q;

    //////////////////////////////////////////////////
    // shared compare
    //////////////////////////////////////////////////

    // signed ops extend with the sign bit, unsigned with zero
    assign sgn = (op_q == amo_pkg::OP_MIN) || (op_q == amo_pkg::OP_MAX);

    // one subtractor, borrow out of the extended word is "operand < old"
    assign diff = {sgn & opd_q[MSB], opd_q} - {sgn & old_q[MSB], old_q};
    assign lt   = diff[`AMO_DAT_W];

    //////////////////////////////////////////////////
    // write-back word
    //////////////////////////////////////////////////

    always_comb begin
        case (op_q)
            amo_pkg::OP_ADD  : mem.wdt = opd_q + old_q;
            amo_pkg::OP_XOR  : mem.wdt = opd_q ^ old_q;
            amo_pkg::OP_AND  : mem.wdt = opd_q & old_q;
            amo_pkg::OP_OR   : mem.wdt = opd_q | old_q;
            amo_pkg::OP_MIN,
            amo_pkg::OP_MINU : mem.wdt = lt ? opd_q : old_q;
            amo_pkg::OP_MAX,
            amo_pkg::OP_MAXU : mem.wdt = lt ? old_q : opd_q;
            // swap and plain write pass the operand
            default          : mem.wdt = opd_q;
        endcase
    end

endmodule

`default_nettype wire

/* amo_wait_timer.sv */
// wait-state timer: pulses done a fixed number of cycles after start
`timescale 1ns/1ps
`default_nettype none

`include "amo_settings.svh"

module amo_wait_timer (
    input  wire  clk,
    input  wire  arst_n,
    input  wire  tmr_start,
    output logic tmr_done
);

    localparam int W     = `AMO_MEM_WAIT;
    // at least one bit, also for zero wait states
    localparam int CNT_W = $clog2(W + 2);

    logic [CNT_W-1:0] cnt;

    // down-counter, loads only while idle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt <= '0;
        end else if (tmr_start && cnt == '0 && W != 0) begin
            cnt <= CNT_W'(W);
        end else if (cnt != '0) begin
            cnt <= cnt - CNT_W'(1);
        end
    end

    // zero wait states answer in the start cycle
    assign tmr_done = (W == 0) ? tmr_start : (cnt == CNT_W'(1));

endmodule

`default_nettype wire

/* amo_mem_if.sv */
// memory access bus between the controller, the operand path and the memory
`timescale 1ns/1ps
`default_nettype none

`include "amo_settings.svh"

interface amo_mem_if;

    // strobe and direction
    logic                  en;
    logic                  wen;
    // word address and data
    logic [`AMO_ADR_W-1:0] adr;
    logic [`AMO_DAT_W-1:0] wdt;
    logic [`AMO_DAT_W-1:0] rdt;

    // controller side, strobes and address
    modport ctl (output en, output wen, output adr);

    // operand side, write-back word out, old word in
    modport opd (output wdt, input rdt);

    // memory side
    modport mem (input en, input wen, input adr, input wdt, output rdt);

endinterface

`default_nettype wire

/* amo_pkg.sv */
// amo unit package: request opcode and controller state types
`default_nettype none

package amo_pkg;

    //////////////////////////////////////////////////
    // request opcodes
    //////////////////////////////////////////////////

    typedef enum logic [3:0] {
        OP_READ  = 4'd0,   // plain read
        OP_WRITE = 4'd1,   // plain write
        OP_SWAP  = 4'd2,
        OP_ADD   = 4'd3,   // wraps modulo 2^32
        OP_XOR   = 4'd4,
        OP_AND   = 4'd5,
        OP_OR    = 4'd6,
        OP_MIN   = 4'd7,   // signed
        OP_MAX   = 4'd8,   // signed
        OP_MINU  = 4'd9,
        OP_MAXU  = 4'd10
    } amo_op_e;

    //////////////////////////////////////////////////
    // controller states
    //////////////////////////////////////////////////

    typedef enum logic [2:0] {
        ST_IDLE    = 3'd0,   // ready for a request
        ST_RD_WAIT = 3'd1,
        ST_RD_STB  = 3'd2,   // read strobe
        ST_WR_WAIT = 3'd3,
        ST_WR_STB  = 3'd4,   // write strobe
        ST_RESP    = 3'd5    // response pulse
    } amo_state_e;

endpackage

`default_nettype wire

/* amo_settings.svh */
// amo unit settings: bus widths and memory wait states
`ifndef AMO_SETTINGS_SVH
`define AMO_SETTINGS_SVH

//////////////////////////////////////////////////
// bus widths
//////////////////////////////////////////////////

// word address width, 64 words
`define AMO_ADR_W 6

// data word width
`define AMO_DAT_W 32

//////////////////////////////////////////////////
// memory timing
//////////////////////////////////////////////////

// wait cycles before the strobe of each access phase
`define AMO_MEM_WAIT 2

`endif
